/* Makefile */
# Verilator simulation of moving_var_top and its testbench

VERILATOR ?= verilator
TOP       ?= moving_var_tb
FILELIST  ?= moving_var_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j $(JOBS)
PASS_TEXT ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

/* moving_var_top.f */
verilog/moving_var_pkg.sv
verilog/window_stats_if.sv
verilog/sample_squarer.sv
verilog/window_averager.sv
verilog/variance_combiner.sv
verilog/moving_var_top.sv
verification/moving_var_tb.sv

/* verification/moving_var_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module moving_var_tb;

    localparam int SAMPLE_WIDTH    = moving_var_pkg::DEFAULT_SAMPLE_WIDTH;
    localparam int LOG2_WINDOW     = moving_var_pkg::DEFAULT_LOG2_WINDOW;
    localparam int WINDOW_LEN      = 2**LOG2_WINDOW;
    localparam int LATENCY         = 8;     // accept to output in cycles
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_GAP         = 3;
    localparam int WATCHDOG_MARGIN = 100;
    localparam int NUM_ROWS        = 10;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    typedef struct packed {
        sample_t     value;                 // first sample of the row
        sample_t     step;                  // added after each sample
        logic [15:0] count;                 // samples or idle cycles
        logic        valid;
        logic        alt;                   // negate before stepping
        logic        gaps;                  // random idle cycles after samples
        logic        rst;                   // reset before the row
    } row_t;

    // ##########################################################################
    // stimulus table
    // ##########################################################################

    localparam row_t STIM [NUM_ROWS] = '{
        '{16'sd25,     16'sd0,  16'd20, 1'b1, 1'b0, 1'b0, 1'b0},  // fill then constant
        '{16'sd100,    16'sd1,  16'd24, 1'b1, 1'b1, 1'b0, 1'b0},  // 100, -99, ...
        '{-16'sd50,    16'sd7,  16'd30, 1'b1, 1'b0, 1'b0, 1'b0},  // ramp up
        '{16'sd0,      16'sd0,  16'd5,  1'b0, 1'b0, 1'b0, 1'b0},
        '{-16'sd32768, -16'sd1, 16'd24, 1'b1, 1'b1, 1'b0, 1'b0},  // min and max
        '{-16'sd3,     16'sd1,  16'd40, 1'b1, 1'b0, 1'b1, 1'b0},
        '{16'sd9,      -16'sd2, 16'd10, 1'b1, 1'b0, 1'b0, 1'b1},  // reset mid-stream
        '{16'sd500,    16'sd0,  16'd10, 1'b1, 1'b0, 1'b1, 1'b0},
        '{-16'sd7,     16'sd0,  16'd20, 1'b1, 1'b0, 1'b1, 1'b0},
        '{-16'sd1,     -16'sd1, 16'd20, 1'b1, 1'b1, 1'b0, 1'b1}   // -1, 0, ...
    };

    logic                             clk;
    logic                             arst_n;
    sample_t                          din;
    logic                             din_valid;
    sample_t                          mean;
    logic signed [2*SAMPLE_WIDTH-1:0] variance;
    logic                             dout_valid;

    integer                      seed = 32'hf196;
    longint                      cycle = 0;
    int                          value_errors = 0;
    int                          other_errors = 0;
    sample_t                     window_q [$];
    longint                      exp_mean [$];
    longint                      exp_var [$];
    longint                      exp_cycle [$];
    moving_var_pkg::fill_state_t model_state;

    moving_var_top moving_var_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .din        (din),
        .din_valid  (din_valid),
        .mean       (mean),
        .variance   (variance),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        if (dout_valid) begin
            if (exp_mean.size() == 0) begin
                $display("ERROR at %0t: dout_valid high with no result expected", $time);
                other_errors++;
            end else begin
                check_value("mean", exp_mean.pop_front(), longint'(mean));
                check_value("variance", exp_var.pop_front(), longint'(variance));
                check_value("arrival cycle", exp_cycle.pop_front(), cycle);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        check_outputs();                    // outputs settled since the rising edge
    endtask

    // ##########################################################################
    // reference model
    // ##########################################################################

    task automatic push_expected();
        longint sum;
        longint sumsq;
        longint m;
        sum   = 0;
        sumsq = 0;
        foreach (window_q[i]) begin
            sum   += longint'(window_q[i]);
            sumsq += longint'(window_q[i]) * longint'(window_q[i]);
        end
        m = sum >>> LOG2_WINDOW;            // floor toward minus infinity
        exp_mean.push_back(m);
        exp_var.push_back((sumsq >>> LOG2_WINDOW) - m * m);
        exp_cycle.push_back(cycle + LATENCY);
    endtask

    task automatic drive_sample(input sample_t value);
        next_cycle();
        din       = value;
        din_valid = 1'b1;
        window_q.push_back(value);
        if (window_q.size() > WINDOW_LEN) begin
            void'(window_q.pop_front());
        end
        if (window_q.size() == WINDOW_LEN) begin
            if (model_state == moving_var_pkg::FILLING) begin
                model_state = moving_var_pkg::FULL;
                $display("%0t: window state %s", $time, model_state.name());
            end
            push_expected();
        end
    endtask

    task automatic drive_idle();
        next_cycle();
        din       = sample_t'($random(seed));   // junk while idle
        din_valid = 1'b0;
    endtask

    task automatic apply_reset();
        next_cycle();
        arst_n    = 1'b0;
        din_valid = 1'b0;
        window_q.delete();
        exp_mean.delete();
        exp_var.delete();
        exp_cycle.delete();
        model_state = moving_var_pkg::FILLING;
        repeat (RESET_CYCLES) next_cycle();
        arst_n = 1'b1;
    endtask

    function automatic int run_cycles();
        int total;
        total = RESET_CYCLES + 3 * LATENCY;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (STIM[r].rst) begin
                total += RESET_CYCLES + 1;
            end
            total += int'(STIM[r].count) * (STIM[r].gaps ? MAX_GAP + 1 : 1);
        end
        return total;
    endfunction

    // ##########################################################################
    // main sequence and watchdog
    // ##########################################################################

    initial begin
        sample_t cur;
        int      gap;
        arst_n      = 1'b0;
        din         = '0;
        din_valid   = 1'b0;
        model_state = moving_var_pkg::FILLING;
        repeat (RESET_CYCLES) next_cycle();
        arst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (STIM[r].rst) begin
                apply_reset();
            end
            cur = STIM[r].value;
            for (int k = 0; k < int'(STIM[r].count); k++) begin
                if (STIM[r].valid) begin
                    drive_sample(cur);
                    cur = (STIM[r].alt ? -cur : cur) + STIM[r].step;
                    if (STIM[r].gaps) begin
                        gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                        repeat (gap) drive_idle();
                    end
                end else begin
                    drive_idle();
                end
            end
        end
        for (int i = 0; i < 2 * LATENCY && exp_mean.size() != 0; i++) begin
            drive_idle();
        end
        repeat (LATENCY) drive_idle();      // stray outputs would show here
        if (exp_mean.size() != 0) begin
            $display("ERROR: %0d expected results never appeared", exp_mean.size());
            other_errors++;
        end
        $display("%0d value mismatches, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (run_cycles() + WATCHDOG_MARGIN) @(posedge clk);
        $display("ERROR: timeout, the test did not finish within %0d cycles",
                 run_cycles() + WATCHDOG_MARGIN);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/moving_var_pkg.sv */
`default_nettype none

package moving_var_pkg;

    // ##########################################################################
    // window fill state
    // ##########################################################################

    typedef enum logic {
        FILLING,                                // window not yet written through
        FULL                                    // every slot holds a live sample
    } fill_state_t;

    // ##########################################################################
    // defaults for the top level
    // ##########################################################################

    localparam int DEFAULT_SAMPLE_WIDTH = 16;   // bits per signed sample
    localparam int DEFAULT_LOG2_WINDOW  = 4;    // 16 sample window

endpackage

`default_nettype wire

/* verilog/moving_var_top.sv */
`timescale 1ns/1ps
`default_nettype none

module moving_var_top #(
    parameter int SAMPLE_WIDTH = moving_var_pkg::DEFAULT_SAMPLE_WIDTH,
    parameter int LOG2_WINDOW  = moving_var_pkg::DEFAULT_LOG2_WINDOW
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire signed [SAMPLE_WIDTH-1:0]    din,
    input  wire                              din_valid,
    output logic signed [SAMPLE_WIDTH-1:0]   mean,
    output logic signed [2*SAMPLE_WIDTH-1:0] variance,
    output logic                             dout_valid
);

    logic signed [SAMPLE_WIDTH-1:0]   sq_sample;
    logic signed [2*SAMPLE_WIDTH-1:0] sq_square;
    logic                             sq_valid;

    window_stats_if #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) stats_if ();

    // ##########################################################################
    // din -> squarer (3) -> averager (1) -> combiner (4)
    // ##########################################################################

    sample_squarer #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) sample_squarer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din),
        .din_valid (din_valid),
        .sq_sample (sq_sample),
        .sq_square (sq_square),
        .sq_valid  (sq_valid)
    );

    window_averager #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .LOG2_WINDOW  (LOG2_WINDOW)
    ) window_averager_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sq_sample (sq_sample),
        .sq_square (sq_square),
        .sq_valid  (sq_valid),
        .stats     (stats_if.source)
    );

    variance_combiner #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .LOG2_WINDOW  (LOG2_WINDOW)
    ) variance_combiner_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .stats      (stats_if.sink),
        .mean       (mean),
        .variance   (variance),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

/* verilog/sample_squarer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_squarer #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire signed [SAMPLE_WIDTH-1:0]   din,
    input  wire                             din_valid,
    output logic signed [SAMPLE_WIDTH-1:0]  sq_sample,
    output logic signed [2*SAMPLE_WIDTH-1:0] sq_square,
    output logic                            sq_valid
);

    typedef logic signed [SAMPLE_WIDTH-1:0]   sample_t;
    typedef logic signed [2*SAMPLE_WIDTH-1:0] square_t;

    localparam int STAGES = 3;

    sample_t           smp_pipe [STAGES];       // sample rides beside the product
    square_t           prod_s2;
    square_t           prod_s3;
    logic [STAGES-1:0] vld_pipe;

    // ##########################################################################
    // valid delay line
    // ##########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[STAGES-2:0], din_valid};
        end
    end

    // ##########################################################################
    // data path
    // ##########################################################################

    always_ff @(posedge clk) begin
        smp_pipe[0] <= din;                     // stage 1, input register
        for (int i = 1; i < STAGES; i++) begin
            smp_pipe[i] <= smp_pipe[i-1];
        end
        prod_s2 <= smp_pipe[0] * smp_pipe[0];   // stage 2, multiply
        prod_s3 <= prod_s2;                     // stage 3, output register
    end

    assign sq_sample = smp_pipe[STAGES-1];
    assign sq_square = prod_s3;
    assign sq_valid  = vld_pipe[STAGES-1];

    // a square of the most negative sample still fits below the sign bit
    a_square_sign: assert property (
        @(posedge clk) disable iff (!arst_n)
        sq_valid |-> !sq_square[2*SAMPLE_WIDTH-1]
    ) else $error("sample_squarer: negative square %0d", sq_square);

endmodule

`default_nettype wire

/* verilog/variance_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

module variance_combiner #(
    parameter int SAMPLE_WIDTH = 16,
    parameter int LOG2_WINDOW  = 4
) (
    input  wire                              clk,
    input  wire                              arst_n,
    window_stats_if.sink                     stats,
    output logic signed [SAMPLE_WIDTH-1:0]   mean,
    output logic signed [2*SAMPLE_WIDTH-1:0] variance,
    output logic                             dout_valid
);

    typedef logic signed [SAMPLE_WIDTH-1:0]   sample_t;
    typedef logic signed [2*SAMPLE_WIDTH-1:0] square_t;
    typedef logic [LOG2_WINDOW:0]             cnt_t;

    localparam int STAGES     = 3;
    localparam int WINDOW_LEN = 2**LOG2_WINDOW;

    sample_t           mean_pipe [STAGES];
    square_t           mean_sq_pipe [STAGES];
    square_t           msq_s2;                  // mean squared, stage 2
    square_t           msq_s3;
    logic [STAGES-1:0] vld_pipe;
    logic [STAGES-1:0] full_pipe;
    cnt_t              xfer_cnt;                // stats transfers, saturating

    // ##########################################################################
    // control
    // ##########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe   <= '0;
            full_pipe  <= '0;
            dout_valid <= 1'b0;
            xfer_cnt   <= '0;
        end else begin
            vld_pipe   <= {vld_pipe[STAGES-2:0], stats.valid};
            full_pipe  <= {full_pipe[STAGES-2:0], stats.full};
            dout_valid <= vld_pipe[STAGES-1] & full_pipe[STAGES-1];
            if (stats.valid && xfer_cnt != cnt_t'(WINDOW_LEN)) begin
                xfer_cnt <= xfer_cnt + 1'b1;
            end
        end
    end

    // ##########################################################################
    // mean squarer and subtract
    // ##########################################################################

    always_ff @(posedge clk) begin
        mean_pipe[0]    <= stats.mean;
        mean_sq_pipe[0] <= stats.mean_sq;
        for (int i = 1; i < STAGES; i++) begin
            mean_pipe[i]    <= mean_pipe[i-1];
            mean_sq_pipe[i] <= mean_sq_pipe[i-1];
        end
        msq_s2   <= mean_pipe[0] * mean_pipe[0];
        msq_s3   <= msq_s2;
        variance <= mean_sq_pipe[STAGES-1] - msq_s3;
        mean     <= mean_pipe[STAGES-1];
    end

    // full from the averager may not come before a whole window has passed
    a_full_after_window: assert property (
        @(posedge clk) disable iff (!arst_n)
        (stats.valid && stats.full) |-> (xfer_cnt >= cnt_t'(WINDOW_LEN - 1))
    ) else $error("variance_combiner: full after only %0d transfers", xfer_cnt);

    // a floored negative mean may push the variance just below zero
    a_variance_sign: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dout_valid && !mean[SAMPLE_WIDTH-1]) |-> !variance[2*SAMPLE_WIDTH-1]
    ) else $error("variance_combiner: negative variance %0d", variance);

endmodule

`default_nettype wire

/* verilog/window_averager.sv */
`timescale 1ns/1ps
`default_nettype none

module window_averager #(
    parameter int SAMPLE_WIDTH = 16,
    parameter int LOG2_WINDOW  = 4
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire signed [SAMPLE_WIDTH-1:0]    sq_sample,
    input  wire signed [2*SAMPLE_WIDTH-1:0]  sq_square,
    input  wire                              sq_valid,
    window_stats_if.source                   stats
);

    typedef logic signed [SAMPLE_WIDTH-1:0]               sample_t;
    typedef logic signed [2*SAMPLE_WIDTH-1:0]             square_t;
    typedef logic signed [SAMPLE_WIDTH+LOG2_WINDOW-1:0]   sum_t;
    typedef logic signed [2*SAMPLE_WIDTH+LOG2_WINDOW-1:0] sumsq_t;
    typedef logic [LOG2_WINDOW-1:0]                       ptr_t;
    typedef logic [LOG2_WINDOW:0]                         cnt_t;

    localparam int WINDOW_LEN = 2**LOG2_WINDOW;

    sample_t                     smp_mem [WINDOW_LEN];
    square_t                     sqr_mem [WINDOW_LEN];
    ptr_t                        wr_ptr;        // also points at the oldest entry
    cnt_t                        fill_cnt;
    moving_var_pkg::fill_state_t fill_state;
    logic                        fills_now;
    sum_t                        sum_q;
    sum_t                        sum_next;
    sumsq_t                      sumsq_q;
    sumsq_t                      sumsq_next;
    sample_t                     old_sample;
    square_t                     old_square;
    sum_t                        mean_wide;
    sumsq_t                      mean_sq_wide;

    // ##########################################################################
    // running sums
    // ##########################################################################

    always_comb begin
        if (fill_state == moving_var_pkg::FULL) begin
            old_sample = smp_mem[wr_ptr];
            old_square = sqr_mem[wr_ptr];
        end else begin
            old_sample = '0;                    // empty slot, nothing to drop
            old_square = '0;
        end
        sum_next     = sum_q + sum_t'(sq_sample) - sum_t'(old_sample);
        sumsq_next   = sumsq_q + sumsq_t'(sq_square) - sumsq_t'(old_square);
        mean_wide    = sum_next >>> LOG2_WINDOW;    // floors toward -inf
        mean_sq_wide = sumsq_next >>> LOG2_WINDOW;
    end

    assign fills_now = (fill_cnt == cnt_t'(WINDOW_LEN - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            fill_cnt    <= '0;
            fill_state  <= moving_var_pkg::FILLING;
            sum_q       <= '0;
            sumsq_q     <= '0;
            stats.valid <= 1'b0;
            stats.full  <= 1'b0;
        end else begin
            stats.valid <= sq_valid;
            if (sq_valid) begin
                wr_ptr     <= wr_ptr + 1'b1;
                sum_q      <= sum_next;
                sumsq_q    <= sumsq_next;
                stats.full <= (fill_state == moving_var_pkg::FULL) || fills_now;
                case (fill_state)
                    moving_var_pkg::FILLING: begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fills_now) begin
                            fill_state <= moving_var_pkg::FULL;
                        end
                    end
                    default: begin
                        fill_state <= moving_var_pkg::FULL;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sq_valid) begin
            smp_mem[wr_ptr] <= sq_sample;       // overwrites the entry just read
            sqr_mem[wr_ptr] <= sq_square;
            stats.mean      <= mean_wide[SAMPLE_WIDTH-1:0];
            stats.mean_sq   <= mean_sq_wide[2*SAMPLE_WIDTH-1:0];
        end
    end

    // counter and state machine must agree on when the window is full
    a_fill_cnt: assert property (
        @(posedge clk) disable iff (!arst_n)
        fill_cnt <= cnt_t'(WINDOW_LEN) &&
        ((fill_state == moving_var_pkg::FULL) == (fill_cnt == cnt_t'(WINDOW_LEN)))
    ) else $error("window_averager: fill count %0d in state %s", fill_cnt, fill_state.name());

endmodule

`default_nettype wire

/* verilog/window_stats_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface window_stats_if #(
    parameter int SAMPLE_WIDTH = 16
) ();

    typedef logic signed [SAMPLE_WIDTH-1:0]   sample_t;
    typedef logic signed [2*SAMPLE_WIDTH-1:0] square_t;

    sample_t mean;                              // window sum >>> log2 window
    square_t mean_sq;                           // sum of squares >>> log2 window
    logic    valid;                             // one per window update
    logic    full;                              // only meaningful with valid

    modport source (
        output mean, mean_sq, valid, full
    );

    modport sink (
        input mean, mean_sq, valid, full
    );

endinterface

`default_nettype wire
